// ==== hw/rp_bus_pkg.sv ====
// system bus definitions shared by the decoder and the register slaves, referenced by scope
package rp_bus_pkg;

  localparam int bus_dw_c     = 32;                     // data word
  localparam int bus_aw_c     = 32;                     // byte address
  localparam int region_num_c = 8;                      // decoded regions
  localparam int region_w_c   = $clog2(region_num_c);   // region field, 3 bits
  localparam int region_lsb_c = 20;                     // region field sits above a 1 MB offset

  // region numbers, 3 to 7 are left unmapped
  typedef enum logic [region_w_c-1:0] {
    region_hk  = 'd0,
    region_asg = 'd1,
    region_pid = 'd2
  } reg_region_e;

  localparam logic [bus_dw_c-1:0] hk_id_c = 32'h5250_0a01;  // board id word

  // byte offsets inside a region
  localparam logic [region_lsb_c-1:0] hk_id_ofs_c    = 'h000;
  localparam logic [region_lsb_c-1:0] hk_loop_ofs_c  = 'h004;
  localparam logic [region_lsb_c-1:0] hk_led_ofs_c   = 'h008;
  localparam logic [region_lsb_c-1:0] asg_ctrl_ofs_c = 'h000;  // bit per channel enable
  localparam logic [region_lsb_c-1:0] asg_tbl_ofs_c  = 'h100;  // table base, word per entry
  localparam logic [region_lsb_c-1:0] pid_sp_ofs_c   = 'h000;  // ch a, ch b at +4
  localparam logic [region_lsb_c-1:0] pid_kp_ofs_c   = 'h010;  // ch a, ch b at +4

  // one address word, seen whole or split into region and offset
  typedef union packed {
    logic [bus_aw_c-1:0] word;
    struct packed {
      logic [bus_aw_c-region_lsb_c-region_w_c-1:0] unused;
      logic [region_w_c-1:0]                       region;  // decoder view
      logic [region_lsb_c-1:0]                     offset;  // slave view
    } fld;
  } sys_addr_u;

endpackage

// ==== hw/rp_analog_pkg.sv ====
// sample formats and data path limits of the adc/dac path, referenced by scope
package rp_analog_pkg;

  localparam int adc_raw_w_c = 16;  // pin word, low 2 bits reserved
  localparam int smp_w_c     = 14;  // converter resolution
  localparam int ch_num_c    = 2;   // channels a and b

  typedef logic signed [smp_w_c-1:0] smp_t;  // two's complement sample

  localparam smp_t smp_max_c = smp_t'(8191);   // positive full scale
  localparam smp_t smp_min_c = smp_t'(-8192);  // negative full scale

  // asg table
  localparam int tbl_depth_c = 64;
  localparam int tbl_aw_c    = $clog2(tbl_depth_c);  // play pointer width

  // proportional gain, kp of 256 is unity
  localparam int kp_w_c     = 16;
  localparam int kp_shift_c = 8;

endpackage

// ==== hw/sys_bus_if.sv ====
// one decoded system bus region, the decoder is master and a register bank is slave
interface sys_bus_if;

  rp_bus_pkg::sys_addr_u             addr;   // full address
  logic [rp_bus_pkg::bus_dw_c-1:0]   wdata;
  logic                              wen;    // single cycle write strobe
  logic                              ren;    // single cycle read strobe
  logic [rp_bus_pkg::bus_dw_c-1:0]   rdata;  // valid with ack
  logic                              ack;    // one cycle after the strobe
  logic                              err;

  modport master (output addr, wdata, wen, ren, input rdata, ack, err);
  modport slave (input addr, wdata, wen, ren, output rdata, ack, err);

endinterface

// ==== hw/sys_bus_decoder.sv ====
// splits the cpu system bus into eight regions by address bits 22:20 and muxes the answers back
module sys_bus_decoder (
  input  logic                            adc_clk,
  input  logic                            rst_n_i,
  input  logic [rp_bus_pkg::bus_aw_c-1:0] sys_addr_i,
  input  logic [rp_bus_pkg::bus_dw_c-1:0] sys_wdata_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_ren_i,
  output logic [rp_bus_pkg::bus_dw_c-1:0] sys_rdata_o,
  output logic                            sys_ack_o,
  output logic                            sys_err_o,
  sys_bus_if.master                       hk_o,
  sys_bus_if.master                       asg_o,
  sys_bus_if.master                       pid_o
);

  rp_bus_pkg::sys_addr_u               addr;
  logic [rp_bus_pkg::region_num_c-1:0] cs;         // one hot region select
  logic                                mapped;
  rp_bus_pkg::reg_region_e             region_q;   // region of the access in flight
  logic                                unm_ack_q;  // own answer for empty regions

  assign addr.word = sys_addr_i;
  assign cs        = rp_bus_pkg::region_num_c'(1) << addr.fld.region;
  assign mapped    = cs[rp_bus_pkg::region_hk] | cs[rp_bus_pkg::region_asg]
                   | cs[rp_bus_pkg::region_pid];

  // address and data broadcast, strobes only to the selected region
  assign hk_o.addr   = addr;
  assign hk_o.wdata  = sys_wdata_i;
  assign hk_o.wen    = sys_wen_i & cs[rp_bus_pkg::region_hk];
  assign hk_o.ren    = sys_ren_i & cs[rp_bus_pkg::region_hk];
  assign asg_o.addr  = addr;
  assign asg_o.wdata = sys_wdata_i;
  assign asg_o.wen   = sys_wen_i & cs[rp_bus_pkg::region_asg];
  assign asg_o.ren   = sys_ren_i & cs[rp_bus_pkg::region_asg];
  assign pid_o.addr  = addr;
  assign pid_o.wdata = sys_wdata_i;
  assign pid_o.wen   = sys_wen_i & cs[rp_bus_pkg::region_pid];
  assign pid_o.ren   = sys_ren_i & cs[rp_bus_pkg::region_pid];

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      region_q  <= rp_bus_pkg::region_hk;
      unm_ack_q <= 1'b0;
    end
    else
    begin
      if (sys_wen_i | sys_ren_i)
        region_q <= rp_bus_pkg::reg_region_e'(addr.fld.region);  // held until the ack
      unm_ack_q <= (sys_wen_i | sys_ren_i) & ~mapped;
    end
  end

  // return path follows the region latched at the strobe
  always_comb
  begin
    sys_rdata_o = '0;         // empty regions read zero
    sys_ack_o   = unm_ack_q;
    sys_err_o   = 1'b0;
    case (region_q)
      rp_bus_pkg::region_hk:
      begin
        sys_rdata_o = hk_o.rdata;
        sys_ack_o   = hk_o.ack;
        sys_err_o   = hk_o.err;
      end
      rp_bus_pkg::region_asg:
      begin
        sys_rdata_o = asg_o.rdata;
        sys_ack_o   = asg_o.ack;
        sys_err_o   = asg_o.err;
      end
      rp_bus_pkg::region_pid:
      begin
        sys_rdata_o = pid_o.rdata;
        sys_ack_o   = pid_o.ack;
        sys_err_o   = pid_o.err;
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/analog_frontend.sv ====
// adc capture with negative slope conversion, digital loop switch, dac sum, clamp and dac register
module analog_frontend (
  input  logic                                                 adc_clk,
  input  logic                                                 rst_n_i,
  input  logic [rp_analog_pkg::adc_raw_w_c-1:0]                adc_a_dat_i,
  input  logic [rp_analog_pkg::adc_raw_w_c-1:0]                adc_b_dat_i,
  input  logic                                                 digital_loop_i,
  input  rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0]    asg_i,
  input  rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0]    pid_i,
  output rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0]    adc_o,
  output logic [rp_analog_pkg::smp_w_c-1:0]                    dac_a_dat_o,
  output logic [rp_analog_pkg::smp_w_c-1:0]                    dac_b_dat_o
);

  localparam int sw = rp_analog_pkg::smp_w_c;  // short alias for the slices below

  logic [sw-1:0]        adc_q   [rp_analog_pkg::ch_num_c];  // raw pin register
  logic signed [sw:0]   dac_sum [rp_analog_pkg::ch_num_c];  // one guard bit
  rp_analog_pkg::smp_t  dac_sat [rp_analog_pkg::ch_num_c];

  //////////////////////////////////////////////////////////////////////
  // adc side

  // top 14 bits of the pin word, reserved lsbs dropped
  always_ff @(posedge adc_clk)
  begin
    adc_q[0] <= adc_a_dat_i[rp_analog_pkg::adc_raw_w_c-1 -: sw];
    adc_q[1] <= adc_b_dat_i[rp_analog_pkg::adc_raw_w_c-1 -: sw];
  end

  always_comb
  begin
    for (int ch = 0; ch < rp_analog_pkg::ch_num_c; ch++)
    begin
      dac_sum[ch] = $signed(asg_i[ch]) + $signed(pid_i[ch]);
      // top two bits differ, sum left the 14 bit range
      if (dac_sum[ch][sw] != dac_sum[ch][sw-1])
        dac_sat[ch] = dac_sum[ch][sw] ? rp_analog_pkg::smp_min_c : rp_analog_pkg::smp_max_c;
      else
        dac_sat[ch] = dac_sum[ch][sw-1:0];
      // loop on feeds the dac value back in place of the adc
      adc_o[ch] = digital_loop_i ? dac_sat[ch] : {adc_q[ch][sw-1], ~adc_q[ch][sw-2:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // dac side

  // back to negative slope offset binary, 0 maps to 1fff
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_a_dat_o <= {1'b0, {(sw-1){1'b1}}};
      dac_b_dat_o <= {1'b0, {(sw-1){1'b1}}};
    end
    else
    begin
      dac_a_dat_o <= {dac_sat[0][sw-1], ~dac_sat[0][sw-2:0]};
      dac_b_dat_o <= {dac_sat[1][sw-1], ~dac_sat[1][sw-2:0]};
    end
  end

endmodule

// ==== hw/house_keeping.sv ====
// housekeeping bank in region 0: read-only board id, digital loop bit and led byte
module house_keeping (
  input  logic       adc_clk,
  input  logic       rst_n_i,
  output logic       digital_loop_o,
  output logic [7:0] led_o,
  sys_bus_if.slave   bus_i
);

  logic [rp_bus_pkg::region_lsb_c-1:0] ofs;  // offset inside the region

  assign ofs       = bus_i.addr.fld.offset;
  assign bus_i.err = 1'b0;  // no error responses

  // control registers and ack
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      bus_i.ack      <= 1'b0;
    end
    else
    begin
      bus_i.ack <= bus_i.wen | bus_i.ren;  // every strobe answered next cycle
      if (bus_i.wen)
      begin
        case (ofs)
          rp_bus_pkg::hk_loop_ofs_c: digital_loop_o <= bus_i.wdata[0];
          rp_bus_pkg::hk_led_ofs_c:  led_o          <= bus_i.wdata[7:0];
          default: ;                                  // id is read-only
        endcase
      end
    end
  end

  // read data, registered along with ack
  always_ff @(posedge adc_clk)
  begin
    if (bus_i.ren)
    begin
      case (ofs)
        rp_bus_pkg::hk_id_ofs_c:   bus_i.rdata <= rp_bus_pkg::hk_id_c;
        rp_bus_pkg::hk_loop_ofs_c: bus_i.rdata <= rp_bus_pkg::bus_dw_c'(digital_loop_o);
        rp_bus_pkg::hk_led_ofs_c:  bus_i.rdata <= rp_bus_pkg::bus_dw_c'(led_o);
        default:                   bus_i.rdata <= '0;
      endcase
    end
  end

endmodule

// ==== hw/asg_table.sv ====
// arbitrary signal generator in region 1: 64 entry table played one entry per clock on each channel
module asg_table (
  input  logic                                              adc_clk,
  input  logic                                              rst_n_i,
  output rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0] asg_o,
  sys_bus_if.slave                                          bus_i
);

  localparam int aw = rp_analog_pkg::tbl_aw_c;

  rp_analog_pkg::smp_t                  tbl [rp_analog_pkg::tbl_depth_c];  // waveform memory
  logic [rp_analog_pkg::ch_num_c-1:0]   ena_q;    // channel enables, ctrl bits 1:0
  logic [aw-1:0]                        ptr_q;    // play pointer
  logic [rp_bus_pkg::region_lsb_c-1:0]  ofs;
  logic [aw-1:0]                        tbl_idx;  // word index from the bus
  logic                                 tbl_hit;

  assign ofs       = bus_i.addr.fld.offset;
  assign tbl_idx   = ofs[2 +: aw];
  assign tbl_hit   = (ofs >> (aw + 2)) == (rp_bus_pkg::asg_tbl_ofs_c >> (aw + 2));
  assign bus_i.err = 1'b0;

  // control, pointer and playback register
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ena_q     <= '0;
      ptr_q     <= '0;
      asg_o     <= '0;
      bus_i.ack <= 1'b0;
    end
    else
    begin
      bus_i.ack <= bus_i.wen | bus_i.ren;
      if (bus_i.wen && ofs == rp_bus_pkg::asg_ctrl_ofs_c)
        ena_q <= bus_i.wdata[rp_analog_pkg::ch_num_c-1:0];
      if (ena_q == '0)
        ptr_q <= '0;            // idle, restart from entry 0
      else
        ptr_q <= ptr_q + 1'b1;  // wraps at 64
      for (int ch = 0; ch < rp_analog_pkg::ch_num_c; ch++)
        asg_o[ch] <= ena_q[ch] ? tbl[ptr_q] : '0;  // disabled channel sits at 0
    end
  end

  // table port and bus read data
  always_ff @(posedge adc_clk)
  begin
    if (bus_i.wen && tbl_hit)
      tbl[tbl_idx] <= bus_i.wdata[rp_analog_pkg::smp_w_c-1:0];
    if (bus_i.ren)
    begin
      if (tbl_hit)
        bus_i.rdata <= rp_bus_pkg::bus_dw_c'(tbl[tbl_idx]);  // sign extended entry
      else if (ofs == rp_bus_pkg::asg_ctrl_ofs_c)
        bus_i.rdata <= rp_bus_pkg::bus_dw_c'(ena_q);
      else
        bus_i.rdata <= '0;
    end
  end

endmodule

// ==== hw/pid_prop.sv ====
// proportional controller in region 2, out = kp * (setpoint - adc) >> 8 per channel, saturated
module pid_prop (
  input  logic                                              adc_clk,
  input  logic                                              rst_n_i,
  input  rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0] adc_i,
  output rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0] pid_o,
  sys_bus_if.slave                                          bus_i
);

  localparam int sw = rp_analog_pkg::smp_w_c;
  localparam int kw = rp_analog_pkg::kp_w_c;

  rp_analog_pkg::smp_t               sp_q [rp_analog_pkg::ch_num_c];  // setpoints
  logic signed [kw-1:0]              kp_q [rp_analog_pkg::ch_num_c];  // gains
  logic signed [sw:0]                err  [rp_analog_pkg::ch_num_c];  // 15 bit difference
  logic signed [sw+kw:0]             prod [rp_analog_pkg::ch_num_c];
  logic signed [sw+kw-rp_analog_pkg::kp_shift_c:0] scl [rp_analog_pkg::ch_num_c];
  logic [rp_bus_pkg::region_lsb_c-1:0] ofs;

  assign ofs       = bus_i.addr.fld.offset;
  assign bus_i.err = 1'b0;

  always_comb
  begin
    for (int ch = 0; ch < rp_analog_pkg::ch_num_c; ch++)
    begin
      err[ch]  = sp_q[ch] - $signed(adc_i[ch]);
      prod[ch] = err[ch] * kp_q[ch];
      scl[ch]  = prod[ch][sw+kw:rp_analog_pkg::kp_shift_c];  // arithmetic shift by slicing
    end
  end

  // registers, gain stage output with clamp
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sp_q      <= '{default: '0};
      kp_q      <= '{default: '0};
      pid_o     <= '0;
      bus_i.ack <= 1'b0;
    end
    else
    begin
      bus_i.ack <= bus_i.wen | bus_i.ren;
      for (int ch = 0; ch < rp_analog_pkg::ch_num_c; ch++)
      begin
        if (bus_i.wen && ofs == rp_bus_pkg::pid_sp_ofs_c + rp_bus_pkg::region_lsb_c'(4 * ch))
          sp_q[ch] <= bus_i.wdata[sw-1:0];
        if (bus_i.wen && ofs == rp_bus_pkg::pid_kp_ofs_c + rp_bus_pkg::region_lsb_c'(4 * ch))
          kp_q[ch] <= bus_i.wdata[kw-1:0];
        if (scl[ch] > rp_analog_pkg::smp_max_c)
          pid_o[ch] <= rp_analog_pkg::smp_max_c;
        else if (scl[ch] < rp_analog_pkg::smp_min_c)
          pid_o[ch] <= rp_analog_pkg::smp_min_c;
        else
          pid_o[ch] <= scl[ch][sw-1:0];
      end
    end
  end

  // readback, sign extended
  always_ff @(posedge adc_clk)
  begin
    if (bus_i.ren)
    begin
      bus_i.rdata <= '0;
      for (int ch = 0; ch < rp_analog_pkg::ch_num_c; ch++)
      begin
        if (ofs == rp_bus_pkg::pid_sp_ofs_c + rp_bus_pkg::region_lsb_c'(4 * ch))
          bus_i.rdata <= rp_bus_pkg::bus_dw_c'(sp_q[ch]);
        if (ofs == rp_bus_pkg::pid_kp_ofs_c + rp_bus_pkg::region_lsb_c'(4 * ch))
          bus_i.rdata <= rp_bus_pkg::bus_dw_c'(kp_q[ch]);
      end
    end
  end

endmodule

// ==== hw/rp_top.sv ====
// top of the adc/dac control core, bus decoder plus housekeeping, asg, pid and analog path
module rp_top (
  input  logic                                  adc_clk,
  input  logic                                  rst_n_i,
  input  logic [rp_analog_pkg::adc_raw_w_c-1:0] adc_a_dat_i,
  input  logic [rp_analog_pkg::adc_raw_w_c-1:0] adc_b_dat_i,
  input  logic [rp_bus_pkg::bus_aw_c-1:0]       sys_addr_i,
  input  logic [rp_bus_pkg::bus_dw_c-1:0]       sys_wdata_i,
  input  logic                                  sys_wen_i,
  input  logic                                  sys_ren_i,
  output logic [rp_bus_pkg::bus_dw_c-1:0]       sys_rdata_o,
  output logic                                  sys_ack_o,
  output logic                                  sys_err_o,
  output logic [rp_analog_pkg::smp_w_c-1:0]     dac_a_dat_o,
  output logic [rp_analog_pkg::smp_w_c-1:0]     dac_b_dat_o,
  output logic [7:0]                            led_o
);

  sys_bus_if hk_bus ();   // region 0
  sys_bus_if asg_bus ();  // region 1
  sys_bus_if pid_bus ();  // region 2

  logic                                              digital_loop;
  rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0] adc_smp;  // converted or looped back
  rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0] asg_smp;
  rp_analog_pkg::smp_t [rp_analog_pkg::ch_num_c-1:0] pid_smp;

  //////////////////////////////////////////////////////////////////////
  // system bus

  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_o        (hk_bus),
    .asg_o       (asg_bus),
    .pid_o       (pid_bus)
  );

  house_keeping i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .bus_i          (hk_bus)
  );

  //////////////////////////////////////////////////////////////////////
  // signal sources and analog path

  asg_table i_asg (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .asg_o   (asg_smp),
    .bus_i   (asg_bus)
  );

  pid_prop i_pid (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .adc_i   (adc_smp),
    .pid_o   (pid_smp),  // one register behind the adc samples
    .bus_i   (pid_bus)
  );

  analog_frontend i_afe (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_a_dat_i    (adc_a_dat_i),
    .adc_b_dat_i    (adc_b_dat_i),
    .digital_loop_i (digital_loop),
    .asg_i          (asg_smp),
    .pid_i          (pid_smp),
    .adc_o          (adc_smp),
    .dac_a_dat_o    (dac_a_dat_o),
    .dac_b_dat_o    (dac_b_dat_o)
  );

endmodule

// ==== tests/tb_clock.sv ====
// testbench clock and reset source, 4 unit adc_clk and a 10 cycle low reset
module tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int half_c = 2;  // half period

  initial
  begin
    clk_o = 1'b0;
    forever #half_c clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // released with the other stimulus, 1 unit after the edge
  end

endmodule

// ==== tests/rp_top_assertions.sv ====
// concurrent checks on the rp_top pins, bound into rp_top, with a small model of the dac path
module rp_top_assertions (
  input logic        adc_clk,
  input logic        rst_n_i,
  input logic [15:0] adc_a_dat_i,
  input logic [31:0] sys_addr_i,
  input logic [31:0] sys_wdata_i,
  input logic        sys_wen_i,
  input logic        sys_ren_i,
  input logic        sys_ack_o,
  input logic        sys_err_o,
  input logic [13:0] dac_a_dat_o,
  input logic [13:0] dac_b_dat_o,
  input logic [7:0]  led_o
);

  int unsigned           fail_cnt = 0;  // summed up by the testbench
  rp_bus_pkg::sys_addr_u a;
  logic                  wr_hk;
  logic                  wr_asg;
  logic                  wr_pid;
  logic [13:0]           tbl_m [64];  // asg table as written over the bus
  logic [13:0]           adc_d [3];   // adc pin history, bits 15:2
  logic signed [13:0]    sp_m;        // ch a setpoint
  logic signed [15:0]    kp_m;        // ch a gain
  logic [1:0]            ena_m;
  logic                  loop_m;
  logic [5:0]            play_n;      // entry due at the dac pins
  logic [2:0]            quiet;       // cycles since the last write, saturating
  int                    pid_m;
  int                    asg_m;
  logic [13:0]           exp_a;

  // sign bit kept, rest inverted, same rule both ways
  function automatic int from_code(input logic [13:0] c);
    logic signed [13:0] b;
    b = {c[13], ~c[12:0]};
    return int'(b);
  endfunction

  function automatic logic [13:0] to_code(input int v);
    logic [13:0] b;
    b = v[13:0];
    return {b[13], ~b[12:0]};
  endfunction

  function automatic int clamp(input int v);
    if (v > int'(rp_analog_pkg::smp_max_c))
      return int'(rp_analog_pkg::smp_max_c);
    if (v < int'(rp_analog_pkg::smp_min_c))
      return int'(rp_analog_pkg::smp_min_c);
    return v;
  endfunction

  assign a.word = sys_addr_i;
  assign wr_hk  = sys_wen_i && a.fld.region == rp_bus_pkg::region_hk;
  assign wr_asg = sys_wen_i && a.fld.region == rp_bus_pkg::region_asg;
  assign wr_pid = sys_wen_i && a.fld.region == rp_bus_pkg::region_pid;

  ////////////////////////////////////////////////////////////////////
  // register snoop

  always_ff @(posedge adc_clk)
  begin
    adc_d[0] <= adc_a_dat_i[15:2];
    adc_d[1] <= adc_d[0];
    adc_d[2] <= adc_d[1];
    if (!rst_n_i)
    begin
      sp_m   <= '0;
      kp_m   <= '0;
      ena_m  <= '0;
      loop_m <= 1'b0;
      play_n <= '0;
      quiet  <= '0;
    end
    else
    begin
      quiet  <= sys_wen_i ? 3'd0 : (quiet == 3'd7 ? quiet : quiet + 3'd1);
      play_n <= play_n + 6'd1;
      if (wr_hk && a.fld.offset == rp_bus_pkg::hk_loop_ofs_c)
        loop_m <= sys_wdata_i[0];
      if (wr_pid && a.fld.offset == rp_bus_pkg::pid_sp_ofs_c)
        sp_m <= sys_wdata_i[13:0];
      if (wr_pid && a.fld.offset == rp_bus_pkg::pid_kp_ofs_c)
        kp_m <= sys_wdata_i[15:0];
      if (wr_asg && a.fld.offset >= rp_bus_pkg::asg_tbl_ofs_c)
        tbl_m[a.fld.offset[7:2]] <= sys_wdata_i[13:0];
      if (wr_asg && a.fld.offset == rp_bus_pkg::asg_ctrl_ofs_c)
      begin
        ena_m  <= sys_wdata_i[1:0];
        play_n <= 6'd62;  // entry 0 read next cycle, at the pins 2 later
      end
    end
  end

  // expected dac a code, adc 3 cycles back, asg entry due now
  always_comb
  begin
    pid_m = clamp(((int'(sp_m) - from_code(adc_d[2])) * int'(kp_m))
                  >>> rp_analog_pkg::kp_shift_c);
    asg_m = ena_m[0] ? int'($signed(tbl_m[play_n])) : 0;
    exp_a = to_code(clamp(asg_m + pid_m));
  end

  ////////////////////////////////////////////////////////////////////
  // checks

  reset_state: assert property (@(posedge adc_clk) $rose(rst_n_i) |->
      !sys_ack_o && led_o == 8'd0 && dac_a_dat_o == 14'h1fff && dac_b_dat_o == 14'h1fff)
    else begin $error("reset state wrong at reset release"); fail_cnt++; end

  ack_next_cycle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (sys_wen_i || sys_ren_i) |=> sys_ack_o)
    else begin $error("bus strobe not acknowledged in the next cycle"); fail_cnt++; end

  ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
    else begin $error("bus ack without a strobe one cycle before"); fail_cnt++; end

  err_low: assert property (@(posedge adc_clk) disable iff (!rst_n_i) !sys_err_o)
    else begin $error("sys_err_o raised"); fail_cnt++; end

  led_write: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      (wr_hk && a.fld.offset == rp_bus_pkg::hk_led_ofs_c) |=> led_o == $past(sys_wdata_i[7:0]))
    else begin $error("Error led_write: expected %h, actual %h", $past(sys_wdata_i[7:0]), led_o);
      fail_cnt++; end

  dac_a_path: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      quiet >= 3'd3 && !loop_m |-> dac_a_dat_o == exp_a)
    else begin $error("Error dac_a_path: expected %h, actual %h", exp_a, dac_a_dat_o);
      fail_cnt++; end

  loop_holds: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      quiet >= 3'd3 && loop_m && !ena_m[0] |-> dac_a_dat_o == 14'h1fff)
    else begin $error("Error loop_holds: expected 1fff, actual %h", dac_a_dat_o);
      fail_cnt++; end

  // ch b gain never written, stays 0
  dac_b_idle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      quiet >= 3'd3 && !ena_m[1] |-> dac_b_dat_o == 14'h1fff)
    else begin $error("Error dac_b_idle: expected 1fff, actual %h", dac_b_dat_o);
      fail_cnt++; end

endmodule

bind rp_top rp_top_assertions chk0 (.*);

// ==== tests/tb_rp_top.sv ====
// testbench top for rp_top, walks bus, adc, saturation, asg and loop tests past the bound checks
module tb_rp_top;

  localparam int bus_cycles_c  = 3;    // strobe, ack, turnaround
  localparam int adc_cycles_c  = 200;  // random adc run
  localparam int hold_cycles_c = 80;   // per saturation corner
  localparam int play_cycles_c = 150;  // over two table wraps
  localparam int run_cycles_c  = 20 + (3 * 70 + 20) * bus_cycles_c
                               + 2 * adc_cycles_c + 2 * hold_cycles_c + play_cycles_c;
  localparam int limit_c       = 2 * run_cycles_c * 4;  // twice the run, 4 units per cycle

  logic        adc_clk;
  logic        rst_n;
  logic [15:0] adc_a;
  logic [15:0] adc_b;
  logic [31:0] sys_addr;
  logic [31:0] sys_wdata;
  logic [31:0] sys_rdata;
  logic        sys_wen;
  logic        sys_ren;
  logic        sys_ack;
  logic        sys_err;
  logic [13:0] dac_a;
  logic [13:0] dac_b;
  logic [7:0]  led;
  int          seed     = 32'h3021;
  int          read_errs = 0;
  int          bus_errs  = 0;
  int          total;

  tb_clock clk0 (.clk_o(adc_clk), .rst_n_o(rst_n));

  rp_top dut0 (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_a_dat_i (adc_a),
    .adc_b_dat_i (adc_b),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err),
    .dac_a_dat_o (dac_a),
    .dac_b_dat_o (dac_b),
    .led_o       (led)
  );

  function automatic logic [31:0] reg_addr(input logic [2:0] region, input logic [19:0] ofs);
    rp_bus_pkg::sys_addr_u ad;
    ad.word       = '0;
    ad.fld.region = region;
    ad.fld.offset = ofs;
    return ad.word;
  endfunction

  // one strobe, then wait for ack, starts and ends 1 unit after an edge
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = wr;
    sys_ren   = !wr;
    @(posedge adc_clk);
    #1;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    n       = 0;
    while (!sys_ack && n < 8)
    begin
      @(posedge adc_clk);
      #1;
      n++;
    end
    if (!sys_ack)
    begin
      $display("bus access to %h got no ack", addr);
      bus_errs++;
    end
    rdata = sys_rdata;  // valid with ack
    @(posedge adc_clk);
    #1;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic check_read(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    bus_access(1'b0, addr, '0, got);
    if (got !== exp)
    begin
      $display("Error %s: expected %h, actual %h", name, exp, got);
      read_errs++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #1;
  endtask

  // new random words on both adc pins, each held for one full cycle
  task automatic drive_random_adc(input int cycles);
    repeat (cycles)
    begin
      adc_a = 16'($random(seed));
      adc_b = 16'($random(seed));
      @(posedge adc_clk);
      #1;
    end
  endtask

  // asg stopped, table base + step * i, sample width kept by the dut
  task automatic fill_table(input int base, input int step);
    write_reg(reg_addr(rp_bus_pkg::region_asg, rp_bus_pkg::asg_ctrl_ofs_c), 32'd0);
    for (int i = 0; i < 64; i++)
      write_reg(reg_addr(rp_bus_pkg::region_asg, rp_bus_pkg::asg_tbl_ofs_c + 20'(4 * i)),
                32'(base + step * i));
  endtask

  task automatic play_asg_a(input int cycles);
    write_reg(reg_addr(rp_bus_pkg::region_asg, rp_bus_pkg::asg_ctrl_ofs_c), 32'd1);
    wait_cycles(cycles);
    write_reg(reg_addr(rp_bus_pkg::region_asg, rp_bus_pkg::asg_ctrl_ofs_c), 32'd0);
  endtask

  initial
  begin
    #(limit_c);
    $display("timeout, tests still running after %0d time units", limit_c);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    adc_a     = 16'h7ffc;  // code for 0
    adc_b     = 16'h7ffc;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    @(posedge rst_n);
    wait_cycles(2);
    // bus map
    check_read("hk_id", reg_addr(rp_bus_pkg::region_hk, rp_bus_pkg::hk_id_ofs_c),
               rp_bus_pkg::hk_id_c);
    write_reg(reg_addr(rp_bus_pkg::region_hk, rp_bus_pkg::hk_led_ofs_c), 32'ha5);
    check_read("hk_led", reg_addr(rp_bus_pkg::region_hk, rp_bus_pkg::hk_led_ofs_c), 32'ha5);
    check_read("unmapped", reg_addr(3'd5, 20'h0), 32'd0);
    // adc through pid, gain -1
    write_reg(reg_addr(rp_bus_pkg::region_pid, rp_bus_pkg::pid_kp_ofs_c), 32'd256);
    check_read("pid_kp", reg_addr(rp_bus_pkg::region_pid, rp_bus_pkg::pid_kp_ofs_c), 32'd256);
    drive_random_adc(adc_cycles_c);
    adc_a = 16'h7ffc;
    // saturation corners
    fill_table(8191, 0);
    write_reg(reg_addr(rp_bus_pkg::region_pid, rp_bus_pkg::pid_sp_ofs_c), 32'd1000);
    play_asg_a(hold_cycles_c);
    fill_table(-8192, 0);
    write_reg(reg_addr(rp_bus_pkg::region_pid, rp_bus_pkg::pid_sp_ofs_c), 32'(-1000));
    play_asg_a(hold_cycles_c);
    // playback, pid off
    write_reg(reg_addr(rp_bus_pkg::region_pid, rp_bus_pkg::pid_kp_ofs_c), 32'd0);
    write_reg(reg_addr(rp_bus_pkg::region_pid, rp_bus_pkg::pid_sp_ofs_c), 32'd0);
    fill_table(-3150, 100);  // distinct entries
    play_asg_a(play_cycles_c);
    // digital loop
    write_reg(reg_addr(rp_bus_pkg::region_hk, rp_bus_pkg::hk_loop_ofs_c), 32'd1);
    write_reg(reg_addr(rp_bus_pkg::region_pid, rp_bus_pkg::pid_kp_ofs_c), 32'd256);
    drive_random_adc(adc_cycles_c);
    total = read_errs + bus_errs + int'(dut0.chk0.fail_cnt);
    $display("read errors %0d, bus errors %0d, assertion failures %0d",
             read_errs, bus_errs, dut0.chk0.fail_cnt);
    if (total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== rp_top.f ====
hw/rp_bus_pkg.sv
hw/rp_analog_pkg.sv
hw/sys_bus_if.sv
hw/sys_bus_decoder.sv
hw/analog_frontend.sv
hw/house_keeping.sv
hw/asg_table.sv
hw/pid_prop.sv
hw/rp_top.sv
tests/tb_clock.sv
tests/rp_top_assertions.sv
tests/tb_rp_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the rp_top testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rp_top.f --top-module tb_rp_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rp_top +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0
